//--- hw/addr_router_defs.svh
// build-time sizes for the address router
// include wherever a width or count is needed; the guard allows repeated includes
`ifndef ADDR_ROUTER_DEFS_SVH
`define ADDR_ROUTER_DEFS_SVH

// number of target ports behind the router
`define AR_NUM_PORTS 4

// number of rules in the runtime address map
`define AR_NUM_RULES 6

// request payload widths
`define AR_ADDR_W 32
`define AR_ID_W 4
`define AR_DATA_W 32

// input buffer entries
// upstream starts with this many credits
`define AR_BUF_DEPTH 4

// credits the router holds per target port out of reset
`define AR_PORT_CREDITS 2

`endif

//--- hw/addr_router_pkg.sv
// shared types of the address router
// modules refer to these by addr_router_pkg::name
`include "addr_router_defs.svh"

package addr_router_pkg;

  // payload fields of a single-beat request
  typedef logic [`AR_ADDR_W-1:0] addr_t;
  typedef logic [`AR_ID_W-1:0] id_t;
  typedef logic [`AR_DATA_W-1:0] data_t;

  // selects one target port
  typedef logic [$clog2(`AR_NUM_PORTS)-1:0] port_idx_t;

  // per-port credit count, must hold the full reset value
  typedef logic [$clog2(`AR_PORT_CREDITS + 1)-1:0] credit_t;

  // one address map entry
  // matches start_addr <= addr < end_addr
  typedef struct packed {
    port_idx_t port_idx;
    addr_t     start_addr;
    addr_t     end_addr;
  } rule_t;

  // request as it travels through buffer and out to targets
  typedef struct packed {
    addr_t addr;
    id_t   id;
    data_t data;
  } req_t;

  // dispatch control, dispatch means the buffer has a head
  typedef enum logic {
    rtr_idle,
    rtr_dispatch
  } rtr_state_t;

endpackage

//--- hw/addr_decode.sv
// combinational address decoder that maps an address onto a target port
// the highest matching rule index wins and unmapped addresses go to default or error
// clk_i only samples the map consistency checks
`timescale 1ns/1ps
`include "addr_router_defs.svh"

module addr_decode (
  input  logic                                       clk_i,
  // address under decode
  input  addr_router_pkg::addr_t                     addr_i,
  // runtime map held stable during traffic
  input  addr_router_pkg::rule_t [`AR_NUM_RULES-1:0] addr_map_i,
  // fallback for unmapped addresses
  input  logic                                       en_default_i,
  input  addr_router_pkg::port_idx_t                 default_idx_i,
  // decode result
  output addr_router_pkg::port_idx_t                 port_idx_o,
  output logic                                       dec_valid_o,
  output logic                                       dec_error_o
);

  always_comb begin
    // without a match the default port is used if enabled and an error otherwise
    port_idx_o  = en_default_i ? default_idx_i : '0;
    dec_valid_o = 1'b0;
    dec_error_o = ~en_default_i;

    // later rules overwrite earlier ones
    // so the highest index match is what remains
    for (int i = 0; i < `AR_NUM_RULES; i++) begin
      if ((addr_i >= addr_map_i[i].start_addr) && (addr_i < addr_map_i[i].end_addr)) begin
        port_idx_o  = addr_map_i[i].port_idx;
        dec_valid_o = 1'b1;
        dec_error_o = 1'b0;
      end
    end
  end

  // map consistency checked on every clock edge
  for (genvar i = 0; i < `AR_NUM_RULES; i++) begin : gen_rule_chk
    // an inverted range would silently never match
    a_rule_range: assert property (
      @(posedge clk_i) addr_map_i[i].start_addr <= addr_map_i[i].end_addr
    ) else begin
      $error("addr_decode: rule %0d start %h above end %h", i,
             addr_map_i[i].start_addr, addr_map_i[i].end_addr);
    end
  end

endmodule

//--- hw/req_router.sv
// request side of the router with input buffer, head decode and dispatch
// credits flow both ways so upstream gets one back per buffer pop
// and each target port is fed only while its counter is above zero
`timescale 1ns/1ps
`include "addr_router_defs.svh"

module req_router (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  // upstream push of one beat per request
  input  logic                                       req_valid_i,
  input  addr_router_pkg::req_t                      req_i,
  output logic                                       crd_o,
  // address map configuration
  input  addr_router_pkg::rule_t [`AR_NUM_RULES-1:0] addr_map_i,
  input  logic                                       en_default_i,
  input  addr_router_pkg::port_idx_t                 default_idx_i,
  // target side with payload shared by all ports
  output logic [`AR_NUM_PORTS-1:0]                   req_valid_o,
  output addr_router_pkg::req_t                      req_o,
  input  logic [`AR_NUM_PORTS-1:0]                   crd_i,
  // decode error response
  output logic                                       err_valid_o,
  output addr_router_pkg::id_t                       err_id_o
);

  localparam int unsigned PTR_W = (`AR_BUF_DEPTH > 1) ? $clog2(`AR_BUF_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(`AR_BUF_DEPTH + 1);

  // circular input buffer
  addr_router_pkg::req_t buf_q [`AR_BUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_d;

  addr_router_pkg::rtr_state_t state_q;
  addr_router_pkg::rtr_state_t state_d;

  // credits held towards each target
  addr_router_pkg::credit_t credit_q [`AR_NUM_PORTS];

  addr_router_pkg::req_t      head;
  addr_router_pkg::port_idx_t dec_idx;
  logic                       dec_error;
  logic                       head_valid;
  logic                       has_credit;
  logic                       push;
  logic                       pop;
  logic                       send;
  logic [`AR_NUM_PORTS-1:0]   send_vec;

  // decode always looks at the buffer head
  addr_decode u_addr_decode (
    .clk_i         (clk_i),
    .addr_i        (head.addr),
    .addr_map_i    (addr_map_i),
    .en_default_i  (en_default_i),
    .default_idx_i (default_idx_i),
    .port_idx_o    (dec_idx),
    // a miss with default enabled also steers to dec_idx
    .dec_valid_o   (),
    .dec_error_o   (dec_error)
  );

  assign head       = buf_q[rd_ptr_q];
  assign head_valid = (state_q == addr_router_pkg::rtr_dispatch);
  assign push       = req_valid_i;

  // head leaves when its port has a credit or straight away on error
  assign has_credit = (credit_q[dec_idx] != '0);
  assign send       = head_valid & ~dec_error & has_credit;
  assign pop        = head_valid & (dec_error | has_credit);

  always_comb begin
    for (int p = 0; p < `AR_NUM_PORTS; p++) begin
      send_vec[p] = send && (dec_idx == addr_router_pkg::port_idx_t'(p));
    end
  end

  always_comb begin
    case ({push, pop})
      2'b10:   count_d = count_q + 1'b1;
      2'b01:   count_d = count_q - 1'b1;
      default: count_d = count_q;
    endcase
    // dispatch whenever something sits in the buffer
    state_d = (count_d != '0) ? addr_router_pkg::rtr_dispatch : addr_router_pkg::rtr_idle;
  end

  // buffer storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      state_q  <= addr_router_pkg::rtr_idle;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`AR_BUF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`AR_BUF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_d;
      state_q <= state_d;
    end
  end

  // per-port credit counters where return and spend may coincide
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int p = 0; p < `AR_NUM_PORTS; p++) begin
        credit_q[p] <= addr_router_pkg::credit_t'(`AR_PORT_CREDITS);
      end
    end else begin
      for (int p = 0; p < `AR_NUM_PORTS; p++) begin
        case ({crd_i[p], send_vec[p]})
          2'b10:   credit_q[p] <= credit_q[p] + 1'b1;
          2'b01:   credit_q[p] <= credit_q[p] - 1'b1;
          default: credit_q[p] <= credit_q[p];
        endcase
      end
    end
  end

  // output valids and the upstream credit as one cycle pulses
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_valid_o <= '0;
      err_valid_o <= 1'b0;
      crd_o       <= 1'b0;
    end else begin
      req_valid_o <= send_vec;
      err_valid_o <= pop & dec_error;
      crd_o       <= pop;
    end
  end

  // payload only qualified by the valids above
  always_ff @(posedge clk_i) begin
    if (send) begin
      req_o <= head;
    end
    if (pop && dec_error) begin
      err_id_o <= head.id;
    end
  end

  // upstream pushed without holding a credit
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) req_valid_i |-> (count_q != CNT_W'(`AR_BUF_DEPTH))
  ) else $error("req_router: push into a full input buffer");

  // a target handed back a credit it did not owe
  for (genvar p = 0; p < `AR_NUM_PORTS; p++) begin : gen_crd_chk
    a_crd_max: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      credit_q[p] <= addr_router_pkg::credit_t'(`AR_PORT_CREDITS)
    ) else $error("req_router: port %0d credit count above limit", p);
  end

endmodule

//--- hw/addr_router_top.sv
// top level of the address router
// connects the outside ports straight to the request router
`timescale 1ns/1ps
`include "addr_router_defs.svh"

module addr_router_top (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  // upstream request channel
  input  logic                                       req_valid_i,
  input  addr_router_pkg::req_t                      req_i,
  output logic                                       crd_o,
  // address map
  input  addr_router_pkg::rule_t [`AR_NUM_RULES-1:0] addr_map_i,
  input  logic                                       en_default_i,
  input  addr_router_pkg::port_idx_t                 default_idx_i,
  // target ports
  output logic [`AR_NUM_PORTS-1:0]                   req_valid_o,
  output addr_router_pkg::req_t                      req_o,
  input  logic [`AR_NUM_PORTS-1:0]                   crd_i,
  // decode errors
  output logic                                       err_valid_o,
  output addr_router_pkg::id_t                       err_id_o
);

  req_router u_req_router (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .crd_o         (crd_o),
    .addr_map_i    (addr_map_i),
    .en_default_i  (en_default_i),
    .default_idx_i (default_idx_i),
    .req_valid_o   (req_valid_o),
    .req_o         (req_o),
    .crd_i         (crd_i),
    .err_valid_o   (err_valid_o),
    .err_id_o      (err_id_o)
  );

endmodule

//--- verif/tb_addr_router.sv
// testbench for the address router top level
// replays the golden file: map rules, default setup, credit holds and requests
// with their expected port or decode error, then checks every output pulse
`timescale 1ns/1ps
`include "addr_router_defs.svh"

module tb_addr_router;

  localparam int NP = `AR_NUM_PORTS;
  localparam int CRED = `AR_PORT_CREDITS;

  logic clk_i = 1'b0;
  logic rst_n_i;
  logic req_valid_i;
  addr_router_pkg::req_t req_i;
  logic crd_o;
  addr_router_pkg::rule_t [`AR_NUM_RULES-1:0] addr_map_i;
  logic en_default_i;
  addr_router_pkg::port_idx_t default_idx_i;
  logic [NP-1:0] req_valid_o;
  addr_router_pkg::req_t req_o;
  logic [NP-1:0] crd_i;
  logic err_valid_o;
  addr_router_pkg::id_t err_id_o;

  // golden commands in file order
  byte cmd_tag[$];
  logic [31:0] cmd_a[$];
  logic [31:0] cmd_b[$];
  logic [31:0] cmd_c[$];
  logic [31:0] cmd_d[$];
  bit cmd_err[$];

  // expectations indexed by push order
  addr_router_pkg::req_t exp_req[$];
  addr_router_pkg::port_idx_t exp_port[$];
  bit exp_err[$];
  int push_edge[$];
  bit fast[$];

  int n_req = 0;
  int n_sent = 0;
  int n_seen = 0;
  int crd_cnt = 0;
  int edge_cnt = 0;
  int delivered [NP] = '{default: 0};
  int returned [NP] = '{default: 0};
  logic [NP-1:0] hold_mask;
  bit loaded = 1'b0;
  int load_errs = 0;
  int val_errs = 0;
  int proto_errs = 0;
  int end_errs = 0;

  addr_router_top u_addr_router_top (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .crd_o         (crd_o),
    .addr_map_i    (addr_map_i),
    .en_default_i  (en_default_i),
    .default_idx_i (default_idx_i),
    .req_valid_o   (req_valid_o),
    .req_o         (req_o),
    .crd_i         (crd_i),
    .err_valid_o   (err_valid_o),
    .err_id_o      (err_id_o)
  );

  // 4 ns clock
  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    edge_cnt <= edge_cnt + 1;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_req(input int idx, input addr_router_pkg::port_idx_t want_port,
                           input addr_router_pkg::port_idx_t got_port,
                           input addr_router_pkg::req_t want, input addr_router_pkg::req_t got);
    if (got_port != want_port) begin
      val_errs++;
      $display("error at %0t: request %0d on port %0d, expected port %0d",
               $time, idx, got_port, want_port);
    end
    if (got != want) begin
      val_errs++;
      $display("error at %0t: request %0d carries addr %h id %h data %h, expected %h %h %h",
               $time, idx, got.addr, got.id, got.data, want.addr, want.id, want.data);
    end
  endtask

  task automatic check_err(input int idx, input addr_router_pkg::id_t want_id,
                           input addr_router_pkg::id_t got_id);
    if (got_id != want_id) begin
      val_errs++;
      $display("error at %0t: request %0d error id %h, expected %h",
               $time, idx, got_id, want_id);
    end
  endtask

  // tags R, D, W, I take a fixed field count; a Q ending in ERR scans one short
  task automatic load_golden();
    int fd;
    int n;
    string line;
    string body;
    byte tag;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    fd = $fopen("verif/addr_router_golden.txt", "r");
    if (fd == 0) begin
      load_errs++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 1 && line[0] != "#") begin
        tag = line[0];
        body = line.substr(1, line.len() - 1);
        a = '0;
        b = '0;
        c = '0;
        d = '0;
        case (tag)
          "R": n = $sscanf(body, "%d %d %h %h", a, b, c, d);
          "Q": n = $sscanf(body, "%h %h %h %d", a, b, c, d);
          "D": n = $sscanf(body, "%d %d", a, b) + 2;
          "W": n = $sscanf(body, "%h", a) + 3;
          "I": n = $sscanf(body, "%d", a) + 3;
          default: n = 0;
        endcase
        if (n < 3 || (n == 3 && tag != "Q")) begin
          load_errs++;
          $display("golden file line not understood: %s", line);
        end else begin
          cmd_tag.push_back(tag);
          cmd_a.push_back(a);
          cmd_b.push_back(b);
          cmd_c.push_back(c);
          cmd_d.push_back(d);
          cmd_err.push_back(n == 3);
          if (tag == "Q") n_req++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      req_valid_i <= 1'b0;
    end
  endtask

  task automatic drain_outputs();
    idle_cycles(1);
    while (n_seen < n_sent) begin
      idle_cycles(1);
    end
  endtask

  // push needs an upstream credit, the buffer has AR_BUF_DEPTH entries
  task automatic push_req(input int i);
    addr_router_pkg::req_t req;
    int p;
    req.addr = cmd_a[i];
    req.id = addr_router_pkg::id_t'(cmd_b[i]);
    req.data = cmd_c[i];
    p = int'(cmd_d[i]);
    @(posedge clk_i);
    while (`AR_BUF_DEPTH - n_sent + crd_cnt <= 0) begin
      req_valid_i <= 1'b0;
      @(posedge clk_i);
    end
    req_valid_i <= 1'b1;
    req_i <= req;
    exp_req.push_back(req);
    exp_port.push_back(addr_router_pkg::port_idx_t'(cmd_d[i]));
    exp_err.push_back(cmd_err[i]);
    push_edge.push_back(edge_cnt);
    // empty router with credit: output two edges after the push edge
    fast.push_back(n_seen == n_sent && (cmd_err[i] || delivered[p] - returned[p] < CRED));
    n_sent++;
  endtask

  initial begin : main
    addr_router_pkg::rule_t rule;
    rst_n_i <= 1'b0;
    req_valid_i <= 1'b0;
    req_i <= '0;
    addr_map_i <= '0;
    en_default_i <= 1'b0;
    default_idx_i <= '0;
    hold_mask <= '0;
    load_golden();
    if (load_errs != 0) begin
      $display("golden file missing or unreadable, no requests were run");
      $display("Test failed");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (5) @(posedge clk_i);
      rst_n_i <= 1'b1;
      for (int i = 0; i < cmd_tag.size(); i++) begin
        case (cmd_tag[i])
          "R": begin
            idle_cycles(1);
            rule.port_idx = addr_router_pkg::port_idx_t'(cmd_b[i]);
            rule.start_addr = cmd_c[i];
            rule.end_addr = cmd_d[i];
            addr_map_i[int'(cmd_a[i])] <= rule;
          end
          // config only changes with no traffic in flight
          "D": begin
            drain_outputs();
            en_default_i <= cmd_a[i][0];
            default_idx_i <= addr_router_pkg::port_idx_t'(cmd_b[i]);
          end
          "W": begin
            idle_cycles(1);
            hold_mask <= cmd_a[i][NP-1:0];
          end
          "I": idle_cycles(int'(cmd_a[i]));
          default: push_req(i);
        endcase
      end
      drain_outputs();
      idle_cycles(3);
      if (crd_cnt != n_req) begin
        end_errs++;
        $display("error at %0t: %0d upstream credits returned for %0d requests",
                 $time, crd_cnt, n_req);
      end
      $display("errors: %0d value, %0d protocol, %0d end of run", val_errs, proto_errs, end_errs);
      if (val_errs + proto_errs + end_errs == 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

  // targets return credits at random, only for delivered requests
  initial begin : credit_return
    logic [31:0] lcg_state;
    logic [NP-1:0] crd_vec;
    lcg_state = 32'haf74;
    crd_i <= '0;
    forever begin
      @(posedge clk_i);
      lcg_state = lcg_next(lcg_state);
      crd_vec = '0;
      for (int p = 0; p < NP; p++) begin
        if (rst_n_i && !hold_mask[p] && delivered[p] > returned[p] && lcg_state[20 + p]) begin
          crd_vec[p] = 1'b1;
          returned[p] <= returned[p] + 1;
        end
      end
      crd_i <= crd_vec;
    end
  end

  // outputs are sampled on the falling edge, half a cycle after they change
  initial begin : monitor
    int nvalid;
    int got_p;
    int idx;
    forever begin
      @(negedge clk_i);
      if (rst_n_i) begin
        if (crd_o) begin
          crd_cnt++;
          if (crd_cnt > n_sent) begin
            proto_errs++;
            $display("upstream credit at %0t with no request pushed to free it", $time);
          end
        end
        nvalid = $countones(req_valid_o) + (err_valid_o ? 1 : 0);
        got_p = 0;
        for (int p = 0; p < NP; p++) begin
          if (req_valid_o[p]) got_p = p;
        end
        if (nvalid > 1) begin
          proto_errs++;
          $display("more than one output valid in the same cycle at %0t", $time);
        end else if (nvalid == 1 && n_seen >= n_sent) begin
          proto_errs++;
          $display("output at %0t with no request waiting for it", $time);
        end else if (nvalid == 1) begin
          idx = n_seen;
          if (err_valid_o != exp_err[idx]) begin
            val_errs++;
            $display("error at %0t: request %0d decode error %0b, expected %0b",
                     $time, idx, err_valid_o, exp_err[idx]);
          end else if (err_valid_o) begin
            check_err(idx, exp_req[idx].id, err_id_o);
          end else begin
            check_req(idx, exp_port[idx], addr_router_pkg::port_idx_t'(got_p),
                      exp_req[idx], req_o);
            delivered[got_p]++;
            if (delivered[got_p] - returned[got_p] > CRED) begin
              proto_errs++;
              $display("port %0d got more requests than it has credits at %0t", got_p, $time);
            end
          end
          if (fast[idx] && edge_cnt != push_edge[idx] + 3) begin
            val_errs++;
            $display("error at %0t: request %0d took %0d edges after push, expected 2",
                     $time, idx, edge_cnt - push_edge[idx] - 1);
          end
          n_seen++;
        end
      end
    end
  end

  // bound is request count times (port credits plus 40) cycles of 4 ns
  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = n_req * (CRED + 40);
    repeat (limit) @(posedge clk_i);
    $display("timeout after %0d cycles, %0d of %0d requests never came out",
             limit, n_req - n_seen, n_req);
    $display("Test failed");
    $finish;
  end

endmodule

//--- verif/addr_router_golden.txt
# R rule port start end | D enable port | W held port mask | I idle cycles
# Q addr id data expected, a port number or ERR for a decode error
R 0 0 00000000 00001000
R 1 1 00001000 00002000
R 2 2 00010000 00020000
R 3 3 00020000 00030000
# rules 4 and 5 overlap rules 1 and 2, the higher index wins
R 4 3 00001800 00001900
R 5 0 00018000 00019000
D 1 2
Q 00000010 1 11110000 0
Q 00001004 2 22220001 1
Q 00010020 3 33330002 2
Q 00020030 4 44440003 3
Q 00001880 5 55550004 3
Q 00001900 6 66660005 1
Q 00018100 7 77770006 0
Q 00005000 8 88880007 2
Q 00030000 9 99990008 2
# hold port 1 credits so the third port 1 request stalls
W 2
Q 00001100 a aaaa0009 1
Q 00001200 b bbbb000a 1
Q 00001300 c cccc000b 1
Q 00000200 d dddd000c 0
I 20
W 0
Q 00001400 e eeee000d 1
D 0 0
Q 00005000 f ffff000e ERR
Q 80000000 0 0000000f ERR
Q 00001010 1 11110010 1
Q 00002000 2 22220011 ERR
Q 00019000 3 33330012 2
Q 0000fffc 4 44440013 ERR

//--- files.f
+incdir+hw
hw/addr_router_pkg.sv
hw/addr_decode.sv
hw/req_router.sv
hw/addr_router_top.sv
verif/tb_addr_router.sv

//--- run.sh
#!/bin/sh
# build the address router testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module tb_addr_router \
  -o sim_addr_router || { echo "build failed"; exit 1; }
out="$(./obj_dir/sim_addr_router)"
echo "$out"
echo "$out" | grep -q "Test completed successfully" && echo "PASS" || { echo "FAIL"; exit 1; }
